// File: rtl/miniAluPkg.sv
package miniAluPkg;

   // ------------------------------------------------
   // Instruction format
   // ------------------------------------------------

   localparam int InstrWidth   = 28;
   localparam int RegAddrWidth = 8;

   // Sources that read the SMUL result halves
   localparam logic [RegAddrWidth-1:0] RegRl = 8'd254;
   localparam logic [RegAddrWidth-1:0] RegRh = 8'd255;

   // Unlisted codes decode as NOP
   typedef enum logic [3:0]
   {
      OpNop  = 4'd0,
      OpAdd  = 4'd1,
      OpSub  = 4'd2,
      OpSmul = 4'd3,
      OpSto  = 4'd4,
      OpBle  = 4'd5,
      OpJmp  = 4'd6,
      OpCall = 4'd7,
      OpRet  = 4'd8,
      OpLed  = 4'd9,
      OpShl  = 4'd10
   } opcode_e;

   // dest doubles as branch target, src1:src0 as STO immediate
   typedef struct packed
   {
      opcode_e                 op;
      logic [RegAddrWidth-1:0] dest;
      logic [RegAddrWidth-1:0] src1;
      logic [RegAddrWidth-1:0] src0;
   } instr_t;

   localparam instr_t InstrNop = '{op: OpNop, dest: '0, src1: '0, src0: '0};

   // ------------------------------------------------
   // Execute unit result selection
   // ------------------------------------------------

   typedef enum logic [2:0]
   {
      SelImm = 3'd0,
      SelAdd = 3'd1,
      SelSub = 3'd2,
      SelMul = 3'd3,
      SelShl = 3'd4
   } aluSel_e;

endpackage

// File: rtl/execCtrlIf.sv
interface execCtrlIf
#(
   parameter int DataWidth = 16
);
   import miniAluPkg::*;

   aluSel_e                 aluSel;
   logic [RegAddrWidth-1:0] dest;
   logic [RegAddrWidth-1:0] src0;
   logic [RegAddrWidth-1:0] src1;
   logic [DataWidth-1:0]    immediate;
   logic                    regWrite;
   logic                    mulWrite;
   logic                    ledWrite;
   logic                    branchLe;
   logic                    jump;
   logic                    call;
   logic                    ret;
   // Execute stage holds a bubble from a pause or reset
   logic                    stall;

   modport ctrl (output aluSel, dest, src0, src1, immediate, regWrite, mulWrite,
                 ledWrite, branchLe, jump, call, ret, stall);
   modport dat (input aluSel, dest, src0, src1, immediate, regWrite, mulWrite,
                ledWrite, branchLe, jump, call, ret, stall);

endinterface

// File: rtl/instructionMemory.sv
module instructionMemory
#(
   parameter int ProgAddrWidth = 8
)
(
   input  logic                                Clock,
   input  logic                                iLoadEn,
   input  logic [ProgAddrWidth-1:0]            iLoadAddr,
   input  logic [miniAluPkg::InstrWidth-1:0]   iLoadData,
   input  logic [ProgAddrWidth-1:0]            pc,
   output miniAluPkg::instr_t                  instr
);
   import miniAluPkg::*;

   localparam int Depth = 2 ** ProgAddrWidth;

   instr_t progMem [Depth];

   // Host load port, only used while the core is paused
   always_ff @(posedge Clock)
   begin
      if (iLoadEn)
      begin
         progMem[iLoadAddr] <= instr_t'(iLoadData);
      end
   end

   // Fetch is combinational from pc
   assign instr = progMem[pc];

endmodule

// File: rtl/instructionPointer.sv
module instructionPointer
#(
   parameter int ProgAddrWidth = 8
)
(
   input  logic                     Clock,
   input  logic                     arstN,
   input  logic                     iRun,
   input  logic                     branchTaken,
   execCtrlIf.dat                   ctrl,
   output logic [ProgAddrWidth-1:0] pc
);

   logic [ProgAddrWidth-1:0] nextAddr;
   logic [ProgAddrWidth-1:0] retAddr;
   logic [ProgAddrWidth-1:0] target;

   assign target = ProgAddrWidth'(ctrl.dest);

   // ------------------------------------------------
   // Fetch address select
   // ------------------------------------------------

   // Redirect in the same cycle, so no delay slot
   always_comb
   begin
      if (ctrl.ret)
      begin
         pc = retAddr;
      end
      else if (branchTaken || ctrl.jump)
      begin
         pc = target;
      end
      else
      begin
         pc = nextAddr;
      end
   end

   // Paused edge keeps pc, including a pending redirect
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         nextAddr <= '0;
         retAddr  <= '0;
      end
      else
      begin
         if (iRun)
         begin
            nextAddr <= pc + 1'b1;
         end
         else
         begin
            nextAddr <= pc;
         end
         // Counter still points just past the CALL
         if (ctrl.call)
         begin
            retAddr <= nextAddr;
         end
      end
   end

endmodule

// File: rtl/miniAluControl.sv
module miniAluControl
(
   input  logic               Clock,
   input  logic               arstN,
   input  logic               iRun,
   input  miniAluPkg::instr_t instr,
   execCtrlIf.ctrl            ctrl
);
   import miniAluPkg::*;

   instr_t execInstr;
   logic   pauseBubble;

   // ------------------------------------------------
   // Fetch/execute pipeline register
   // ------------------------------------------------

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         execInstr   <= InstrNop;
         pauseBubble <= 1'b1;
      end
      else
      begin
         pauseBubble <= !iRun;
         if (iRun)
         begin
            execInstr <= instr;
         end
         else
         begin
            execInstr <= InstrNop;
         end
      end
   end

   assign ctrl.dest      = execInstr.dest;
   assign ctrl.src0      = execInstr.src0;
   assign ctrl.src1      = execInstr.src1;
   assign ctrl.immediate = ctrl.DataWidth'({execInstr.src1, execInstr.src0});
   assign ctrl.stall     = pauseBubble;

   // ------------------------------------------------
   // Opcode decode
   // ------------------------------------------------

   always_comb
   begin
      ctrl.aluSel   = SelImm;
      ctrl.regWrite = 1'b0;
      ctrl.mulWrite = 1'b0;
      ctrl.ledWrite = 1'b0;
      ctrl.branchLe = 1'b0;
      ctrl.jump     = 1'b0;
      ctrl.call     = 1'b0;
      ctrl.ret      = 1'b0;
      case (execInstr.op)
         OpAdd:
         begin
            ctrl.aluSel   = SelAdd;
            ctrl.regWrite = 1'b1;
         end
         OpSub:
         begin
            ctrl.aluSel   = SelSub;
            ctrl.regWrite = 1'b1;
         end
         OpShl:
         begin
            ctrl.aluSel   = SelShl;
            ctrl.regWrite = 1'b1;
         end
         OpSto:
         begin
            ctrl.regWrite = 1'b1;
         end
         // Product goes to RL/RH only
         OpSmul:
         begin
            ctrl.aluSel   = SelMul;
            ctrl.mulWrite = 1'b1;
         end
         OpBle:  ctrl.branchLe = 1'b1;
         OpJmp:  ctrl.jump     = 1'b1;
         OpCall:
         begin
            ctrl.jump = 1'b1;
            ctrl.call = 1'b1;
         end
         OpRet:  ctrl.ret      = 1'b1;
         OpLed:  ctrl.ledWrite = 1'b1;
         default:
         begin
            ctrl.aluSel = SelImm;
         end
      endcase
   end

endmodule

// File: rtl/registerFile.sv
module registerFile
#(
   parameter int DataWidth = 16
)
(
   input  logic                   Clock,
   input  logic                   arstN,
   execCtrlIf.dat                 ctrl,
   input  logic [DataWidth-1:0]   result,
   input  logic [2*DataWidth-1:0] product,
   output logic [DataWidth-1:0]   operand0,
   output logic [DataWidth-1:0]   operand1
);
   import miniAluPkg::*;

   localparam int Depth = 2 ** RegAddrWidth;

   logic [DataWidth-1:0]    regMem [Depth];
   logic [DataWidth-1:0]    regRl;
   logic [DataWidth-1:0]    regRh;
   logic [RegAddrWidth-1:0] lastDest;
   logic [DataWidth-1:0]    lastResult;
   logic                    lastWrite;

   always_ff @(posedge Clock)
   begin
      if (ctrl.regWrite)
      begin
         regMem[ctrl.dest] <= result;
      end
      // Bubbles leave the last write in place
      if (!ctrl.stall)
      begin
         lastDest   <= ctrl.dest;
         lastResult <= result;
      end
   end

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         regRl     <= '0;
         regRh     <= '0;
         lastWrite <= 1'b0;
      end
      else
      begin
         if (ctrl.mulWrite)
         begin
            regRl <= product[DataWidth-1:0];
            regRh <= product[2*DataWidth-1:DataWidth];
         end
         if (!ctrl.stall)
         begin
            lastWrite <= ctrl.regWrite;
         end
      end
   end

   // ------------------------------------------------
   // Forwarding and special sources
   // ------------------------------------------------

   function automatic logic [DataWidth-1:0] readSource(input logic [RegAddrWidth-1:0] addr);
      if (lastWrite && (addr == lastDest))
      begin
         return lastResult;
      end
      else if (addr == RegRl)
      begin
         return regRl;
      end
      else if (addr == RegRh)
      begin
         return regRh;
      end
      return regMem[addr];
   endfunction

   always_comb
   begin
      operand0 = readSource(ctrl.src0);
      operand1 = readSource(ctrl.src1);
   end

endmodule

// File: rtl/executeUnit.sv
module executeUnit
#(
   parameter int DataWidth = 16
)
(
   input  logic                   Clock,
   input  logic                   arstN,
   execCtrlIf.dat                 ctrl,
   input  logic [DataWidth-1:0]   operand0,
   input  logic [DataWidth-1:0]   operand1,
   output logic [DataWidth-1:0]   result,
   output logic [2*DataWidth-1:0] product,
   output logic                   branchTaken,
   output logic [7:0]             oLed,
   output logic                   oLedValid
);
   import miniAluPkg::*;

   logic [DataWidth-1:0] shifted;

   // ------------------------------------------------
   // Arithmetic
   // ------------------------------------------------

   // Signed operands, full width product
   assign product = $signed(operand1) * $signed(operand0);

   // Oversized shift clears the result
   assign shifted = (operand0 >= DataWidth) ? '0 : (operand1 << operand0);

   always_comb
   begin
      case (ctrl.aluSel)
         SelAdd:  result = operand1 + operand0;
         SelSub:  result = operand1 - operand0;
         SelMul:  result = product[DataWidth-1:0];
         SelShl:  result = shifted;
         default: result = ctrl.immediate;
      endcase
   end

   // Signed compare for BLE
   assign branchTaken = ctrl.branchLe && ($signed(operand1) <= $signed(operand0));

   // ------------------------------------------------
   // LED port
   // ------------------------------------------------

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         oLed      <= 8'd0;
         oLedValid <= 1'b0;
      end
      else
      begin
         // One cycle strobe per LED instruction
         oLedValid <= ctrl.ledWrite;
         if (ctrl.ledWrite)
         begin
            oLed <= operand1[7:0];
         end
      end
   end

endmodule

// File: rtl/miniAlu.sv
module miniAlu
#(
   parameter int ProgAddrWidth = 8,
   parameter int DataWidth     = 16
)
(
   input  logic                              Clock,
   input  logic                              arstN,
   input  logic                              iRun,
   input  logic                              iLoadEn,
   input  logic [ProgAddrWidth-1:0]          iLoadAddr,
   input  logic [miniAluPkg::InstrWidth-1:0] iLoadData,
   output logic [7:0]                        oLed,
   output logic                              oLedValid
);
   import miniAluPkg::*;

   logic [ProgAddrWidth-1:0] pc;
   instr_t                   instr;
   logic [DataWidth-1:0]     operand0;
   logic [DataWidth-1:0]     operand1;
   logic [DataWidth-1:0]     result;
   logic [2*DataWidth-1:0]   product;
   logic                     branchTaken;

   execCtrlIf #(.DataWidth(DataWidth)) ctrlIf ();

   // ------------------------------------------------
   // Fetch
   // ------------------------------------------------

   instructionMemory #(.ProgAddrWidth(ProgAddrWidth)) instructionMemory_i
   (
      .Clock     (Clock),
      .iLoadEn   (iLoadEn),
      .iLoadAddr (iLoadAddr),
      .iLoadData (iLoadData),
      .pc        (pc),
      .instr     (instr)
   );

   instructionPointer #(.ProgAddrWidth(ProgAddrWidth)) instructionPointer_i
   (
      .Clock       (Clock),
      .arstN       (arstN),
      .iRun        (iRun),
      .branchTaken (branchTaken),
      .ctrl        (ctrlIf.dat),
      .pc          (pc)
   );

   // ------------------------------------------------
   // Execute
   // ------------------------------------------------

   miniAluControl miniAluControl_i
   (
      .Clock (Clock),
      .arstN (arstN),
      .iRun  (iRun),
      .instr (instr),
      .ctrl  (ctrlIf.ctrl)
   );

   registerFile #(.DataWidth(DataWidth)) registerFile_i
   (
      .Clock    (Clock),
      .arstN    (arstN),
      .ctrl     (ctrlIf.dat),
      .result   (result),
      .product  (product),
      .operand0 (operand0),
      .operand1 (operand1)
   );

   executeUnit #(.DataWidth(DataWidth)) executeUnit_i
   (
      .Clock       (Clock),
      .arstN       (arstN),
      .ctrl        (ctrlIf.dat),
      .operand0    (operand0),
      .operand1    (operand1),
      .result      (result),
      .product     (product),
      .branchTaken (branchTaken),
      .oLed        (oLed),
      .oLedValid   (oLedValid)
   );

endmodule

// File: dv/miniAluRef.svh
`ifndef MINI_ALU_REF_SVH
`define MINI_ALU_REF_SVH

typedef logic [7:0] ledQueue_t [$];
typedef instr_t progQueue_t [$];

// Architectural state of the model
logic [DataWidth-1:0] modelRegs [256];
logic [DataWidth-1:0] modelRl;
logic [DataWidth-1:0] modelRh;

function automatic instr_t makeInstr(input opcode_e op, input int dest, input int src1,
                                     input int src0);
   instr_t ins;
   ins.op   = op;
   ins.dest = 8'(dest);
   ins.src1 = 8'(src1);
   ins.src0 = 8'(src0);
   return ins;
endfunction

// Immediate split over src1:src0
function automatic instr_t makeSto(input int dest, input int imm);
   return makeInstr(OpSto, dest, (imm >> 8) & 255, imm & 255);
endfunction

function automatic logic [DataWidth-1:0] readModelSource(input logic [7:0] addr);
   if (addr == RegRl)
   begin
      return modelRl;
   end
   if (addr == RegRh)
   begin
      return modelRh;
   end
   return modelRegs[addr];
endfunction

// ------------------------------------------------
// Instruction set model
// ------------------------------------------------

// Stops at a jump to its own address
function automatic ledQueue_t miniAluRun(input progQueue_t prog, input int maxSteps);
   ledQueue_t              leds;
   instr_t                 ins;
   logic [DataWidth-1:0]   v0;
   logic [DataWidth-1:0]   v1;
   logic [2*DataWidth-1:0] prod;
   int                     pc;
   int                     nextPc;
   int                     retAddr;
   bit                     halted;
   foreach (modelRegs[i])
   begin
      modelRegs[i] = '0;
   end
   modelRl = '0;
   modelRh = '0;
   pc      = 0;
   retAddr = 0;
   halted  = 1'b0;
   for (int step = 0; step < maxSteps && !halted; step++)
   begin
      ins    = prog[pc];
      v0     = readModelSource(ins.src0);
      v1     = readModelSource(ins.src1);
      nextPc = (pc + 1) % 256;
      case (ins.op)
         OpAdd: modelRegs[ins.dest] = v1 + v0;
         OpSub: modelRegs[ins.dest] = v1 - v0;
         OpShl: modelRegs[ins.dest] = (int'(v0) >= DataWidth) ? '0 : v1 << v0;
         OpSto: modelRegs[ins.dest] = {ins.src1, ins.src0};
         OpLed: leds.push_back(v1[7:0]);
         OpSmul:
         begin
            // Sign extended to full width, low half of the product is exact
            prod    = {{DataWidth{v1[DataWidth-1]}}, v1} * {{DataWidth{v0[DataWidth-1]}}, v0};
            modelRl = prod[DataWidth-1:0];
            modelRh = prod[2*DataWidth-1:DataWidth];
         end
         OpBle:
         begin
            if ($signed(v1) <= $signed(v0))
            begin
               nextPc = int'(ins.dest);
            end
         end
         OpJmp:
         begin
            halted = (int'(ins.dest) == pc);
            nextPc = int'(ins.dest);
         end
         OpCall:
         begin
            retAddr = nextPc;
            nextPc  = int'(ins.dest);
         end
         OpRet:   nextPc = retAddr;
         default: ;
      endcase
      pc = nextPc;
   end
   return leds;
endfunction

// ------------------------------------------------
// Directed programs
// ------------------------------------------------

function automatic progQueue_t arithProgram();
   progQueue_t p;
   p.push_back(makeSto(1, 100));
   p.push_back(makeSto(2, 7));
   p.push_back(makeInstr(OpAdd, 3, 1, 2));
   p.push_back(makeInstr(OpLed, 0, 3, 0));
   p.push_back(makeInstr(OpSub, 4, 2, 3));
   p.push_back(makeInstr(OpLed, 0, 4, 0));
   p.push_back(makeSto(5, 3));
   p.push_back(makeInstr(OpShl, 6, 2, 5));
   p.push_back(makeInstr(OpLed, 0, 6, 0));
   p.push_back(makeSto(7, 20));
   p.push_back(makeInstr(OpShl, 8, 1, 7));
   p.push_back(makeInstr(OpLed, 0, 8, 0));
   p.push_back(makeInstr(OpAdd, 1, 1, 1));
   p.push_back(makeInstr(OpAdd, 1, 1, 1));
   p.push_back(makeInstr(OpSub, 1, 1, 2));
   p.push_back(makeInstr(OpLed, 0, 1, 0));
   p.push_back(makeInstr(OpJmp, 16, 0, 0));
   return p;
endfunction

function automatic progQueue_t mulProgram();
   progQueue_t p;
   p.push_back(makeSto(1, -300));
   p.push_back(makeSto(2, 1234));
   p.push_back(makeInstr(OpSmul, 0, 1, 2));
   p.push_back(makeInstr(OpLed, 0, 254, 0));
   p.push_back(makeInstr(OpLed, 0, 255, 0));
   p.push_back(makeInstr(OpSub, 3, 255, 254));
   p.push_back(makeInstr(OpLed, 0, 3, 0));
   p.push_back(makeSto(4, -7));
   p.push_back(makeInstr(OpSmul, 0, 4, 1));
   p.push_back(makeInstr(OpAdd, 5, 254, 255));
   p.push_back(makeInstr(OpLed, 0, 5, 0));
   p.push_back(makeInstr(OpLed, 0, 255, 0));
   p.push_back(makeInstr(OpJmp, 12, 0, 0));
   return p;
endfunction

// Counts 5 down to 1, exits once the counter reaches 0
function automatic progQueue_t loopProgram();
   progQueue_t p;
   p.push_back(makeSto(1, 5));
   p.push_back(makeSto(2, 1));
   p.push_back(makeSto(3, 0));
   p.push_back(makeInstr(OpLed, 0, 1, 0));
   p.push_back(makeInstr(OpSub, 1, 1, 2));
   p.push_back(makeInstr(OpBle, 7, 1, 3));
   p.push_back(makeInstr(OpJmp, 3, 0, 0));
   p.push_back(makeSto(4, 'haa));
   p.push_back(makeInstr(OpLed, 0, 4, 0));
   p.push_back(makeInstr(OpJmp, 9, 0, 0));
   return p;
endfunction

function automatic progQueue_t callProgram();
   progQueue_t p;
   p.push_back(makeSto(1, 'h11));
   p.push_back(makeInstr(OpCall, 7, 0, 0));
   p.push_back(makeSto(1, 'h22));
   p.push_back(makeInstr(OpCall, 7, 0, 0));
   p.push_back(makeSto(2, 'h33));
   p.push_back(makeInstr(OpLed, 0, 2, 0));
   p.push_back(makeInstr(OpJmp, 6, 0, 0));
   p.push_back(makeInstr(OpLed, 0, 1, 0));
   p.push_back(makeInstr(OpRet, 0, 0, 0));
   return p;
endfunction

`endif

// File: dv/miniAluTb.sv
module miniAluTb;
   timeunit 1ns;
   timeprecision 100ps;
   import miniAluPkg::*;

   localparam int ProgAddrWidth = 8;
   localparam int DataWidth     = 16;
   localparam int ClockPeriod   = 8;
   localparam int RunCycles     = 120;
   localparam int NumTests      = 11;
   // Load, reset, run and pause together
   localparam int CyclesPerTest = 2 * RunCycles;

   `include "miniAluRef.svh"

   logic                     Clock;
   logic                     arstN;
   logic                     iRun;
   logic                     iLoadEn;
   logic [ProgAddrWidth-1:0] iLoadAddr;
   logic [InstrWidth-1:0]    iLoadData;
   logic [7:0]               oLed;
   logic                     oLedValid;

   ledQueue_t  expLeds;
   logic [7:0] expLed;
   string      testName;
   bit         checkOn;
   int         errorCount;
   int         passCount;
   int         failCount;

   miniAlu #(.ProgAddrWidth(ProgAddrWidth), .DataWidth(DataWidth)) miniAlu_i
   (
      .Clock     (Clock),
      .arstN     (arstN),
      .iRun      (iRun),
      .iLoadEn   (iLoadEn),
      .iLoadAddr (iLoadAddr),
      .iLoadData (iLoadData),
      .oLed      (oLed),
      .oLedValid (oLedValid)
   );

   always #(ClockPeriod / 2) Clock = ~Clock;

   initial
   begin
      #(NumTests * CyclesPerTest * ClockPeriod * 2);
      $display("Watchdog expired before all tests finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ------------------------------------------------
   // Compare process
   // ------------------------------------------------

   // Sampled mid cycle, away from the DUT's clock edge
   always @(negedge Clock)
   begin
      if (checkOn && oLedValid)
      begin
         assert (expLeds.size() > 0)
         else
         begin
            $display("Test %s: LED write of %02h that the model never makes", testName, oLed);
            errorCount++;
         end
         if (expLeds.size() > 0)
         begin
            expLed = expLeds.pop_front();
            assert (oLed == expLed)
            else
            begin
               $display("Error: test %s expected %02h actual %02h", testName, expLed, oLed);
               errorCount++;
            end
         end
      end
   end

   // ------------------------------------------------
   // Stimulus tasks
   // ------------------------------------------------

   task automatic loadProgram(input progQueue_t words);
      iRun = 1'b0;
      foreach (words[i])
      begin
         iLoadEn   = 1'b1;
         iLoadAddr = ProgAddrWidth'(i);
         iLoadData = words[i];
         @(posedge Clock);
         #1;
      end
      iLoadEn = 1'b0;
   endtask

   task automatic applyReset();
      arstN = 1'b0;
      repeat (4) @(posedge Clock);
      #1;
      arstN = 1'b1;
   endtask

   // pauseAt below 0 runs without a pause
   task automatic runCycles(input int pauseAt, input int pauseLen);
      iRun = 1'b1;
      for (int c = 0; c < RunCycles; c++)
      begin
         @(posedge Clock);
         #1;
         if (c == pauseAt)
         begin
            iRun = 1'b0;
         end
         else if (c == pauseAt + pauseLen)
         begin
            iRun = 1'b1;
         end
      end
      iRun = 1'b0;
      // Let the last LED strobe through
      repeat (2) @(posedge Clock);
      #1;
   endtask

   task automatic checkOutputsCleared();
      assert (oLed == 8'd0 && !oLedValid)
      else
      begin
         $display("Error: test %s expected oLed 00 valid 0 actual oLed %02h valid %0b",
                  testName, oLed, oLedValid);
         errorCount++;
      end
   endtask

   task automatic reportTest(input int errorsBefore);
      assert (expLeds.size() == 0)
      else
      begin
         $display("Test %s: %0d expected LED writes never came", testName, expLeds.size());
         errorCount++;
      end
      if (errorCount == errorsBefore)
      begin
         passCount++;
         $display("Test %s: pass", testName);
      end
      else
      begin
         failCount++;
         $display("Test %s: fail", testName);
      end
   endtask

   task automatic runTest(input string name, input progQueue_t words, input int pauseAt,
                          input int pauseLen);
      int errorsBefore;
      errorsBefore = errorCount;
      testName     = name;
      loadProgram(words);
      applyReset();
      expLeds = miniAluRun(words, RunCycles);
      checkOn = 1'b1;
      runCycles(pauseAt, pauseLen);
      checkOn = 1'b0;
      reportTest(errorsBefore);
   endtask

   // Reset lands while the first LED strobe is high
   task automatic resetMidRun(input progQueue_t words);
      int errorsBefore;
      errorsBefore = errorCount;
      testName     = "resetMidRun";
      loadProgram(words);
      applyReset();
      iRun = 1'b1;
      repeat (5) @(posedge Clock);
      #1;
      arstN = 1'b0;
      #1;
      checkOutputsCleared();
      iRun = 1'b0;
      applyReset();
      checkOutputsCleared();
      expLeds = miniAluRun(words, RunCycles);
      checkOn = 1'b1;
      runCycles(-1, 0);
      checkOn = 1'b0;
      reportTest(errorsBefore);
   endtask

   // ------------------------------------------------
   // Random straight-line programs
   // ------------------------------------------------

   // A written register, or RL/RH
   function automatic int pickSource(input int written[$]);
      int idx;
      idx = int'($urandom_range(0, written.size() + 1));
      if (idx >= written.size())
      begin
         return 254 + idx - written.size();
      end
      return written[idx];
   endfunction

   function automatic progQueue_t randomProgram(input int length);
      progQueue_t words;
      int         written[$];
      int         dest;
      int         opSel;
      for (int n = 0; n < 4; n++)
      begin
         dest = int'($urandom_range(0, 253));
         words.push_back(makeSto(dest, int'($urandom_range(0, 65535))));
         written.push_back(dest);
      end
      for (int n = 0; n < length; n++)
      begin
         dest  = int'($urandom_range(0, 253));
         opSel = int'($urandom_range(0, 5));
         case (opSel)
            0: words.push_back(makeInstr(OpAdd, dest, pickSource(written), pickSource(written)));
            1: words.push_back(makeInstr(OpSub, dest, pickSource(written), pickSource(written)));
            2: words.push_back(makeInstr(OpShl, dest, pickSource(written), pickSource(written)));
            3: words.push_back(makeInstr(OpSmul, 0, pickSource(written), pickSource(written)));
            // Small values keep shift counts in range
            4: words.push_back(makeSto(dest, int'($urandom_range(0, 1) ?
                                                 $urandom_range(0, 15) : $urandom_range(0, 65535))));
            default: words.push_back(makeInstr(OpLed, 0, pickSource(written), 0));
         endcase
         if (opSel < 3 || opSel == 4)
         begin
            written.push_back(dest);
         end
      end
      words.push_back(makeInstr(OpJmp, words.size(), 0, 0));
      return words;
   endfunction

   // ------------------------------------------------
   // Test sequence
   // ------------------------------------------------

   initial
   begin
      void'($urandom(77253));
      Clock      = 1'b0;
      arstN      = 1'b0;
      iRun       = 1'b0;
      iLoadEn    = 1'b0;
      iLoadAddr  = '0;
      iLoadData  = '0;
      checkOn    = 1'b0;
      errorCount = 0;
      passCount  = 0;
      failCount  = 0;
      applyReset();
      runTest("arithChain", arithProgram(), -1, 0);
      runTest("signedMul", mulProgram(), -1, 0);
      runTest("bleLoop", loopProgram(), -1, 0);
      runTest("callRet", callProgram(), -1, 0);
      for (int n = 0; n < 4; n++)
      begin
         runTest($sformatf("random%0d", n), randomProgram(40), -1, 0);
      end
      // First paused edge ends the JMP back to the loop head
      runTest("pauseLoop", loopProgram(), 6, 5);
      // First paused edge ends the first CALL
      runTest("pauseCall", callProgram(), 1, 4);
      resetMidRun(loopProgram());
      $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
               passCount + failCount, passCount, failCount, errorCount);
      if (errorCount == 0 && failCount == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: miniAlu.f
+incdir+dv
rtl/miniAluPkg.sv
rtl/execCtrlIf.sv
rtl/instructionMemory.sv
rtl/instructionPointer.sv
rtl/miniAluControl.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/miniAlu.sv
dv/miniAluTb.sv

// File: Makefile
# Verilator simulation of the miniAlu testbench

VERILATOR ?= verilator
TOP       ?= miniAluTb
FILELIST  ?= miniAlu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$($(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
